// ==== rtl/ahb_pkg.sv ====
//##############################
// AHB-Lite subsystem package
// Bus enums, request/response bundles,
// address map and timer register offsets
//##############################

`default_nettype none

package ahb_pkg;

  // Bus widths
  localparam int AHB_ADDR_W = 32;
  localparam int AHB_DATA_W = 32;
  localparam int AHB_STRB_W = AHB_DATA_W / 8;

  // Transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Transfer size up to the bus width
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // Slave response
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // 46-bit address-phase bundle from the master
  typedef struct packed {
    logic [AHB_ADDR_W-1:0] haddr;
    logic                  hwrite;
    htrans_e               htrans;
    hsize_e                hsize;
    logic [2:0]            hburst;
    logic [3:0]            hprot;
    logic                  hmastlock;
  } ahb_req_t;

  // 34-bit response bundle from a slave
  typedef struct packed {
    logic [AHB_DATA_W-1:0] hrdata;
    hresp_e                hresp;
    logic                  hreadyout;
  } ahb_rsp_t;

  // Slave slots on the node
  localparam int NB_SLAVES = 3;
  localparam int SLV_SRAM  = 0;
  localparam int SLV_TIMER = 1;
  localparam int SLV_ERR   = 2;

  // Address map with inclusive ranges
  localparam logic [AHB_ADDR_W-1:0] SRAM_BASE  = 32'h0000_0000;
  localparam logic [AHB_ADDR_W-1:0] SRAM_LAST  = 32'h0000_03FF;
  localparam logic [AHB_ADDR_W-1:0] TIMER_BASE = 32'h0000_1000;
  localparam logic [AHB_ADDR_W-1:0] TIMER_LAST = 32'h0000_100F;

  // SRAM geometry
  localparam int SRAM_WORDS = 256;
  localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

  // Timer register offsets within its window
  localparam int TMR_OFF_W = 4;
  localparam logic [TMR_OFF_W-1:0] TMR_CTRL   = 4'h0;
  localparam logic [TMR_OFF_W-1:0] TMR_CMP    = 4'h4;
  localparam logic [TMR_OFF_W-1:0] TMR_COUNT  = 4'h8;
  localparam logic [TMR_OFF_W-1:0] TMR_STATUS = 4'hC;

  // CTRL bit positions
  localparam int CTRL_EN_BIT  = 0;
  localparam int CTRL_IRQ_BIT = 1;

endpackage

`default_nettype wire

// ==== rtl/ahb_node.sv ====
//##############################
// AHB-Lite node
// Decodes the address phase to one slave,
// tracks the data-phase owner and muxes
// its response back to the master
//##############################

`timescale 1ns/1ps
`default_nettype none

module ahb_node (
  input  wire logic                                       hclk,
  input  wire logic                                       hreset_n,
  // Single master side
  input  wire ahb_pkg::ahb_req_t                          req_i,
  input  wire logic [ahb_pkg::AHB_DATA_W-1:0]             hwdata_i,
  output ahb_pkg::ahb_rsp_t                               rsp_o,
  // Slave side
  output ahb_pkg::ahb_req_t                               slv_req_o,
  output logic [ahb_pkg::AHB_DATA_W-1:0]                  slv_hwdata_o,
  output logic [ahb_pkg::NB_SLAVES-1:0]                   slv_sel_o,
  output logic                                            hready_o,
  input  wire ahb_pkg::ahb_rsp_t [ahb_pkg::NB_SLAVES-1:0] slv_rsp_i
);

  import ahb_pkg::*;

  // One-hot owner of the current data phase
  logic [NB_SLAVES-1:0] data_sel;
  logic                 hit_sram;
  logic                 hit_timer;

  // Inclusive window check
  function automatic logic in_range(
    logic [AHB_ADDR_W-1:0] addr,
    logic [AHB_ADDR_W-1:0] base,
    logic [AHB_ADDR_W-1:0] last
  );
    return (addr >= base) && (addr <= last);
  endfunction

  // Address decode against the fixed map
  assign hit_sram  = in_range(req_i.haddr, SRAM_BASE, SRAM_LAST);
  assign hit_timer = in_range(req_i.haddr, TIMER_BASE, TIMER_LAST);

  always_comb begin
    slv_sel_o            = '0;
    slv_sel_o[SLV_SRAM]  = hit_sram;
    slv_sel_o[SLV_TIMER] = hit_timer;
    // Anything outside the map lands on the error slave
    slv_sel_o[SLV_ERR]   = !hit_sram && !hit_timer;
  end

  // Request and write data go to every slave and the select picks the owner
  assign slv_req_o    = req_i;
  assign slv_hwdata_o = hwdata_i;

  // Retime the select into the data phase
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      data_sel <= '0;
    end else if (hready_o) begin
      data_sel <= slv_sel_o;
    end
  end

  // Response mux defaults to ready OKAY when nothing owns the data phase
  always_comb begin
    rsp_o.hrdata    = '0;
    rsp_o.hresp     = OKAY;
    rsp_o.hreadyout = 1'b1;
    for (int s = 0; s < NB_SLAVES; s++) begin
      if (data_sel[s]) begin
        rsp_o = slv_rsp_i[s];
      end
    end
  end

  // Muxed ready stalls every slave together
  assign hready_o = rsp_o.hreadyout;

endmodule

`default_nettype wire

// ==== rtl/ahb_sram_slave.sv ====
//##############################
// AHB-Lite SRAM slave
// 256 words, zero wait states,
// byte / halfword / word writes
//##############################

`timescale 1ns/1ps
`default_nettype none

module ahb_sram_slave (
  input  wire logic                           hclk,
  input  wire logic                           hreset_n,
  input  wire logic                           sel_i,
  input  wire ahb_pkg::ahb_req_t              req_i,
  input  wire logic [ahb_pkg::AHB_DATA_W-1:0] hwdata_i,
  input  wire logic                           hready_i,
  output ahb_pkg::ahb_rsp_t                   rsp_o
);

  import ahb_pkg::*;

  logic [AHB_DATA_W-1:0] mem [SRAM_WORDS];

  // Address phase accept
  logic                  accept;
  // Data-phase control
  logic                  dph_active;
  logic                  dph_write;
  // Data-phase payload
  logic [SRAM_IDX_W-1:0] dph_idx;
  hsize_e                dph_size;
  logic [1:0]            dph_off;
  logic [AHB_STRB_W-1:0] wr_mask;
  logic                  wr_en;

  // Byte lanes touched by a write of this size and offset
  function automatic logic [AHB_STRB_W-1:0] lane_mask(hsize_e size, logic [1:0] off);
    logic [AHB_STRB_W-1:0] mask;
    case (size)
      BYTE:    mask = 4'b0001 << off;
      HALF:    mask = off[1] ? 4'b1100 : 4'b0011;
      default: mask = 4'b1111;
    endcase
    return mask;
  endfunction

  assign accept = sel_i && hready_i &&
                  ((req_i.htrans == NONSEQ) || (req_i.htrans == SEQ));

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      dph_active <= 1'b0;
      dph_write  <= 1'b0;
    end else if (hready_i) begin
      dph_active <= accept;
      dph_write  <= accept && req_i.hwrite;
    end
  end

  // Word index, size and lane offset of the accepted transfer
  always_ff @(posedge hclk) begin
    if (accept) begin
      dph_idx  <= req_i.haddr[2 +: SRAM_IDX_W];
      dph_size <= req_i.hsize;
      dph_off  <= req_i.haddr[1:0];
    end
  end

  assign wr_mask = lane_mask(dph_size, dph_off);
  // Commit at the end of the data phase
  assign wr_en   = dph_active && dph_write && hready_i;

  always_ff @(posedge hclk) begin
    if (wr_en) begin
      for (int b = 0; b < AHB_STRB_W; b++) begin
        if (wr_mask[b]) begin
          mem[dph_idx][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read word straight out of the array in the data phase
  always_comb begin
    rsp_o.hrdata    = (dph_active && !dph_write) ? mem[dph_idx] : '0;
    rsp_o.hresp     = OKAY;
    rsp_o.hreadyout = 1'b1;
  end

endmodule

`default_nettype wire

// ==== rtl/ahb_timer_slave.sv ====
//##############################
// AHB-Lite timer slave
// Free-running counter with compare match,
// sticky status and interrupt.
// Reads take one wait state
//##############################

`timescale 1ns/1ps
`default_nettype none

module ahb_timer_slave (
  input  wire logic                           hclk,
  input  wire logic                           hreset_n,
  input  wire logic                           sel_i,
  input  wire ahb_pkg::ahb_req_t              req_i,
  input  wire logic [ahb_pkg::AHB_DATA_W-1:0] hwdata_i,
  input  wire logic                           hready_i,
  output ahb_pkg::ahb_rsp_t                   rsp_o,
  output logic                                irq_o
);

  import ahb_pkg::*;

  logic                  accept;
  // Data-phase control
  logic                  dph_active;
  logic                  dph_write;
  logic                  rd_wait;
  logic [TMR_OFF_W-1:0]  dph_off;
  logic                  wr_en;
  // Registers
  logic [1:0]            ctrl;
  logic [AHB_DATA_W-1:0] cmp;
  logic [AHB_DATA_W-1:0] count;
  logic                  match;
  logic                  hit;

  assign accept = sel_i && hready_i &&
                  ((req_i.htrans == NONSEQ) || (req_i.htrans == SEQ));

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      dph_active <= 1'b0;
      dph_write  <= 1'b0;
      rd_wait    <= 1'b0;
    end else begin
      if (hready_i) begin
        dph_active <= accept;
        dph_write  <= accept && req_i.hwrite;
      end
      // First read data-phase cycle is the wait state
      rd_wait <= accept && !req_i.hwrite;
    end
  end

  // Register offset inside the timer window
  always_ff @(posedge hclk) begin
    if (accept) begin
      dph_off <= req_i.haddr[TMR_OFF_W-1:0];
    end
  end

  // Writes take no wait state
  assign wr_en = dph_active && dph_write && hready_i;

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      ctrl <= '0;
      cmp  <= '0;
    end else if (wr_en) begin
      case (dph_off)
        TMR_CTRL: ctrl <= hwdata_i[1:0];
        TMR_CMP:  cmp  <= hwdata_i;
        // COUNT is read-only and STATUS is handled below
        default: ;
      endcase
    end
  end

  // Compare match only while counting
  assign hit = ctrl[CTRL_EN_BIT] && (count == cmp);

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      count <= '0;
      match <= 1'b0;
    end else begin
      if (hit) begin
        count <= '0;
      end else if (ctrl[CTRL_EN_BIT]) begin
        count <= count + 1'b1;
      end
      // A fresh match wins over a W1C clear in the same cycle
      if (wr_en && (dph_off == TMR_STATUS) && hwdata_i[0]) begin
        match <= 1'b0;
      end
      if (hit) begin
        match <= 1'b1;
      end
    end
  end

  assign irq_o = match && ctrl[CTRL_IRQ_BIT];

  // Read mux with data valid in the second read cycle
  always_comb begin
    rsp_o.hrdata    = '0;
    rsp_o.hresp     = OKAY;
    rsp_o.hreadyout = !rd_wait;
    if (dph_active && !dph_write && !rd_wait) begin
      case (dph_off)
        TMR_CTRL:   rsp_o.hrdata = {{(AHB_DATA_W-2){1'b0}}, ctrl};
        TMR_CMP:    rsp_o.hrdata = cmp;
        TMR_COUNT:  rsp_o.hrdata = count;
        TMR_STATUS: rsp_o.hrdata = {{(AHB_DATA_W-1){1'b0}}, match};
        default:    rsp_o.hrdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ahb_error_slave.sv ====
//##############################
// AHB-Lite default slave
// Two-cycle ERROR response for any
// active transfer outside the map
//##############################

`timescale 1ns/1ps
`default_nettype none

module ahb_error_slave (
  input  wire logic              hclk,
  input  wire logic              hreset_n,
  input  wire logic              sel_i,
  input  wire ahb_pkg::ahb_req_t req_i,
  input  wire logic              hready_i,
  output ahb_pkg::ahb_rsp_t      rsp_o
);

  import ahb_pkg::*;

  typedef enum logic [1:0] {
    ERR_IDLE   = 2'b00,
    ERR_FIRST  = 2'b01,
    ERR_SECOND = 2'b10
  } err_state_e;

  err_state_e state;
  err_state_e state_nxt;
  logic       accept;

  // IDLE and BUSY never reach the FSM
  assign accept = sel_i && hready_i &&
                  ((req_i.htrans == NONSEQ) || (req_i.htrans == SEQ));

  always_comb begin
    state_nxt = state;
    case (state)
      ERR_IDLE:   if (accept) state_nxt = ERR_FIRST;
      ERR_FIRST:  state_nxt = ERR_SECOND;
      // Back-to-back unmapped transfer restarts the sequence
      ERR_SECOND: state_nxt = accept ? ERR_FIRST : ERR_IDLE;
      default:    state_nxt = ERR_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      state <= ERR_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ERROR with ready low, then ERROR with ready high
  always_comb begin
    rsp_o.hrdata    = '0;
    rsp_o.hresp     = (state == ERR_IDLE) ? OKAY : ERROR;
    rsp_o.hreadyout = (state != ERR_FIRST);
  end

endmodule

`default_nettype wire

// ==== rtl/ahb_subsystem_top.sv ====
//##############################
// AHB-Lite subsystem top
// Master port, node and the SRAM,
// timer and default slaves
//##############################

`timescale 1ns/1ps
`default_nettype none

module ahb_subsystem_top (
  input  wire logic                           hclk,
  input  wire logic                           hreset_n,
  input  wire ahb_pkg::ahb_req_t              mst_req_i,
  input  wire logic [ahb_pkg::AHB_DATA_W-1:0] mst_hwdata_i,
  output ahb_pkg::ahb_rsp_t                   mst_rsp_o,
  output logic                                irq_o
);

  import ahb_pkg::*;

  // Broadcast bus from the node
  ahb_req_t                   slv_req;
  logic [AHB_DATA_W-1:0]      slv_hwdata;
  logic [NB_SLAVES-1:0]       slv_sel;
  logic                       hready;
  // Slave responses, packed by slot index
  ahb_rsp_t [NB_SLAVES-1:0]   slv_rsp;

  ahb_node i_ahb_node (
    .hclk         (hclk),
    .hreset_n     (hreset_n),
    .req_i        (mst_req_i),
    .hwdata_i     (mst_hwdata_i),
    .rsp_o        (mst_rsp_o),
    .slv_req_o    (slv_req),
    .slv_hwdata_o (slv_hwdata),
    .slv_sel_o    (slv_sel),
    .hready_o     (hready),
    .slv_rsp_i    (slv_rsp)
  );

  ahb_sram_slave i_ahb_sram_slave (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .sel_i    (slv_sel[SLV_SRAM]),
    .req_i    (slv_req),
    .hwdata_i (slv_hwdata),
    .hready_i (hready),
    .rsp_o    (slv_rsp[SLV_SRAM])
  );

  ahb_timer_slave i_ahb_timer_slave (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .sel_i    (slv_sel[SLV_TIMER]),
    .req_i    (slv_req),
    .hwdata_i (slv_hwdata),
    .hready_i (hready),
    .rsp_o    (slv_rsp[SLV_TIMER]),
    .irq_o    (irq_o)
  );

  // Catches every address the node cannot map
  ahb_error_slave i_ahb_error_slave (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .sel_i    (slv_sel[SLV_ERR]),
    .req_i    (slv_req),
    .hready_i (hready),
    .rsp_o    (slv_rsp[SLV_ERR])
  );

endmodule

`default_nettype wire

// ==== verification/tb_ahb_subsystem.sv ====
//##############################
// AHB-Lite subsystem testbench
// Single master driving SRAM, timer and
// unmapped traffic, checked by assertions
//##############################

`timescale 1ns/1ps
`default_nettype none

module tb_ahb_subsystem;

  import ahb_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 3;
  localparam int N_RAND_WORDS  = 16;
  localparam int N_MERGE_WORDS = 4;
  // Word test, merge test, then timer, error and pipelined traffic
  localparam int N_XFERS       = 2 * N_RAND_WORDS + 4 * N_MERGE_WORDS + 40;
  // Idle gap, address, wait state, data
  localparam int CYC_PER_XFER  = 4;
  // Reset, irq polling and slack
  localparam int MARGIN_CYC    = 400;
  localparam int WATCHDOG_NS   = (N_XFERS * CYC_PER_XFER + MARGIN_CYC) * CLK_PERIOD;

  logic                  hclk;
  logic                  hreset_n;
  ahb_req_t              mst_req;
  logic [AHB_DATA_W-1:0] mst_hwdata;
  ahb_rsp_t              mst_rsp;
  logic                  irq;
  logic                  rsp_rdy;
  logic                  rsp_err;

  // Mirror of the SRAM contents
  logic [AHB_DATA_W-1:0] sram_model [SRAM_WORDS];
  int seed      = 99;
  int err_cnt   = 0;
  int check_cnt = 0;
  int test_cnt  = 0;
  int pass_cnt  = 0;

  ahb_subsystem_top i_ahb_subsystem_top (
    .hclk         (hclk),
    .hreset_n     (hreset_n),
    .mst_req_i    (mst_req),
    .mst_hwdata_i (mst_hwdata),
    .mst_rsp_o    (mst_rsp),
    .irq_o        (irq)
  );

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  assign rsp_rdy = mst_rsp.hreadyout;
  assign rsp_err = (mst_rsp.hresp == ERROR);

  // First ERROR cycle is always followed by the ready ERROR cycle
  err_sequence_completes: assert property (@(posedge hclk) disable iff (!hreset_n)
    (rsp_err && !rsp_rdy) |=> (rsp_err && rsp_rdy))
    else begin
      $display("ERROR: mst_rsp_o.hreadyout 0x%0h hresp 0x%0h, expected 0x1 0x1",
               $sampled(rsp_rdy), $sampled(rsp_err));
      err_cnt++;
    end

  // Ready ERROR only right after a ready-0 ERROR cycle
  err_ready_needs_first: assert property (@(posedge hclk) disable iff (!hreset_n)
    (rsp_err && rsp_rdy) |-> $past(rsp_err && !rsp_rdy))
    else begin
      $display("ERROR: mst_rsp_o.hresp 0x1 with hreadyout 0x1 and no ready-0 ERROR cycle before");
      err_cnt++;
    end

  // No slave stretches a data phase past one wait state
  wait_state_single: assert property (@(posedge hclk) disable iff (!hreset_n)
    !rsp_rdy |=> rsp_rdy)
    else begin
      $display("Wait state on mst_rsp_o lasted longer than one cycle");
      err_cnt++;
    end

  // Idle, OKAY response and quiet irq once reset lifts
  reset_response_idle: assert property (@(posedge hclk)
    $rose(hreset_n) |-> (rsp_rdy && !rsp_err && !irq))
    else begin
      $display("ERROR: after reset hreadyout 0x%0h hresp 0x%0h irq_o 0x%0h, expected 0x1 0x0 0x0",
               $sampled(rsp_rdy), $sampled(rsp_err), $sampled(irq));
      err_cnt++;
    end

  function automatic ahb_req_t make_req(logic [AHB_ADDR_W-1:0] addr, logic write,
                                        hsize_e size, htrans_e trans);
    ahb_req_t req;
    req.haddr     = addr;
    req.hwrite    = write;
    req.htrans    = trans;
    req.hsize     = size;
    req.hburst    = 3'b000;
    req.hprot     = 4'b0011;
    req.hmastlock = 1'b0;
    return req;
  endfunction

  function automatic ahb_req_t idle_req();
    return make_req(SRAM_BASE, 1'b0, WORD, IDLE);
  endfunction

  function automatic logic [AHB_ADDR_W-1:0] sram_addr(logic [SRAM_IDX_W-1:0] idx);
    return SRAM_BASE + {{(AHB_ADDR_W-SRAM_IDX_W-2){1'b0}}, idx, 2'b00};
  endfunction

  function automatic logic [AHB_ADDR_W-1:0] tmr_addr(logic [TMR_OFF_W-1:0] off);
    return TIMER_BASE + {{(AHB_ADDR_W-TMR_OFF_W){1'b0}}, off};
  endfunction

  // Lanes of an aligned 2**size-byte block around the offset take the new data
  function automatic logic [31:0] merge_lanes(logic [31:0] old_word, logic [31:0] wdata,
                                              hsize_e size, logic [1:0] off);
    logic [31:0] result;
    int          nbytes;
    int          first;
    result = old_word;
    nbytes = 1 << int'(size);
    first  = int'(off) & ~(nbytes - 1);
    for (int b = first; b < first + nbytes; b++) begin
      result[8*b +: 8] = wdata[8*b +: 8];
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
      $display("Check failed: %s", what);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - err_before);
    end
  endtask

  // Mid-cycle poll until the data phase completes
  task automatic wait_data_phase(output logic [31:0] rdata, output logic err,
                                 output int waits);
    waits = 0;
    @(negedge hclk);
    while (!mst_rsp.hreadyout) begin
      waits++;
      @(negedge hclk);
    end
    rdata = mst_rsp.hrdata;
    err   = (mst_rsp.hresp == ERROR);
  endtask

  // Single transfer with the bus idle before and after
  task automatic bus_xfer(input logic write, input logic [31:0] addr, input hsize_e size,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err, output int waits);
    @(posedge hclk);
    mst_req <= make_req(addr, write, size, NONSEQ);
    @(posedge hclk);
    mst_req    <= idle_req();
    mst_hwdata <= write ? wdata : '0;
    wait_data_phase(rdata, err, waits);
  endtask

  task automatic bus_write(input logic [31:0] addr, input hsize_e size,
                           input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    bus_xfer(1'b1, addr, size, wdata, rdata, err, waits);
    check_value("mst_rsp_o.hresp", 32'(err), 32'd0);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits), 32'd0);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output int waits);
    logic err;
    bus_xfer(1'b0, addr, WORD, '0, rdata, err, waits);
    check_value("mst_rsp_o.hresp", 32'(err), 32'd0);
  endtask

  task automatic sram_read(input logic [SRAM_IDX_W-1:0] idx, output logic [31:0] rdata);
    int waits;
    bus_read(sram_addr(idx), rdata, waits);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits), 32'd0);
  endtask

  // Timer reads always take exactly one wait state
  task automatic timer_read(input logic [TMR_OFF_W-1:0] off, output logic [31:0] rdata);
    int waits;
    bus_read(tmr_addr(off), rdata, waits);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits), 32'd1);
  endtask

  // Second address phase overlaps the first data phase
  task automatic pipe_read2(input logic [31:0] addr_a, input logic [31:0] addr_b,
                            output logic [31:0] data_a, output logic [31:0] data_b,
                            output int waits_a, output int waits_b);
    logic err_a;
    logic err_b;
    @(posedge hclk);
    mst_req <= make_req(addr_a, 1'b0, WORD, NONSEQ);
    @(posedge hclk);
    mst_req <= make_req(addr_b, 1'b0, WORD, NONSEQ);
    // Address b held through any wait state of a
    wait_data_phase(data_a, err_a, waits_a);
    @(posedge hclk);
    mst_req <= idle_req();
    wait_data_phase(data_b, err_b, waits_b);
    check_value("mst_rsp_o.hresp", 32'(err_a), 32'd0);
    check_value("mst_rsp_o.hresp", 32'(err_b), 32'd0);
  endtask

  task automatic test_sram_words();
    logic [SRAM_IDX_W-1:0] idx_list [N_RAND_WORDS];
    logic [31:0]           rnd;
    logic [31:0]           rdata;
    int                    err_before;
    err_before = err_cnt;
    for (int i = 0; i < N_RAND_WORDS; i++) begin
      rnd = $random(seed);
      idx_list[i] = rnd[SRAM_IDX_W-1:0];
      rnd = $random(seed);
      bus_write(sram_addr(idx_list[i]), WORD, rnd);
      sram_model[idx_list[i]] = rnd;
    end
    for (int i = 0; i < N_RAND_WORDS; i++) begin
      sram_read(idx_list[i], rdata);
      check_value("mst_rsp_o.hrdata", rdata, sram_model[idx_list[i]]);
    end
    report_test("SRAM words", err_before);
  endtask

  task automatic test_sram_merge();
    logic [SRAM_IDX_W-1:0] idx;
    logic [31:0]           addr;
    logic [31:0]           wdata;
    logic [31:0]           rdata;
    int                    err_before;
    err_before = err_cnt;
    for (int k = 0; k < N_MERGE_WORDS; k++) begin
      idx  = SRAM_IDX_W'(8'h40 + k);
      addr = sram_addr(idx);
      wdata = $random(seed);
      bus_write(addr, WORD, wdata);
      sram_model[idx] = wdata;
      // Byte lane walks with k over a full random hwdata word
      wdata = $random(seed);
      bus_write(addr + 32'(k), BYTE, wdata);
      sram_model[idx] = merge_lanes(sram_model[idx], wdata, BYTE, 2'(k));
      wdata = $random(seed);
      bus_write(addr + 32'(2 * (k % 2)), HALF, wdata);
      sram_model[idx] = merge_lanes(sram_model[idx], wdata, HALF, 2'(2 * (k % 2)));
      sram_read(idx, rdata);
      check_value("mst_rsp_o.hrdata", rdata, sram_model[idx]);
    end
    report_test("SRAM byte and halfword merge", err_before);
  endtask

  task automatic test_timer_count();
    logic [31:0] c1;
    logic [31:0] c2;
    int          err_before;
    err_before = err_cnt;
    // CMP at max so no match interferes
    bus_write(tmr_addr(TMR_CMP), WORD, 32'hFFFF_FFFF);
    bus_write(tmr_addr(TMR_CTRL), WORD, 32'h0000_0001);
    timer_read(TMR_COUNT, c1);
    timer_read(TMR_COUNT, c2);
    check_cond(c2 > c1, $sformatf("COUNT did not increase while enabled, 0x%08h then 0x%08h",
                                  c1, c2));
    bus_write(tmr_addr(TMR_CTRL), WORD, 32'h0000_0000);
    timer_read(TMR_COUNT, c1);
    timer_read(TMR_COUNT, c2);
    check_value("mst_rsp_o.hrdata", c2, c1);
    report_test("timer counting", err_before);
  endtask

  task automatic test_timer_irq();
    logic [31:0] c0;
    logic [31:0] cmp_val;
    logic [31:0] rdata;
    int          irq_limit;
    int          cycles;
    int          err_before;
    err_before = err_cnt;
    // Compare just above the count frozen by the last test
    timer_read(TMR_COUNT, c0);
    cmp_val   = c0 + 32'd8;
    irq_limit = int'(cmp_val) + 4;
    bus_write(tmr_addr(TMR_CMP), WORD, cmp_val);
    check_value("irq_o", 32'(irq), 32'd0);
    bus_write(tmr_addr(TMR_CTRL), WORD, 32'h0000_0003);
    cycles = 0;
    while (!irq && cycles < irq_limit) begin
      @(negedge hclk);
      cycles++;
    end
    check_cond(irq, $sformatf("irq_o did not rise within %0d cycles of enabling the timer",
                              irq_limit));
    timer_read(TMR_STATUS, rdata);
    check_value("mst_rsp_o.hrdata", rdata, 32'd1);
    for (int i = 0; i < 3; i++) begin
      timer_read(TMR_COUNT, rdata);
      check_cond(rdata <= cmp_val, $sformatf("COUNT 0x%08h read above CMP 0x%08h",
                                             rdata, cmp_val));
    end
    // Stop counting so no fresh match races the clear
    bus_write(tmr_addr(TMR_CTRL), WORD, 32'h0000_0002);
    bus_write(tmr_addr(TMR_STATUS), WORD, 32'h0000_0001);
    @(negedge hclk);
    check_value("irq_o", 32'(irq), 32'd0);
    timer_read(TMR_STATUS, rdata);
    check_value("mst_rsp_o.hrdata", rdata, 32'd0);
    bus_write(tmr_addr(TMR_CTRL), WORD, 32'h0000_0000);
    report_test("timer match and interrupt", err_before);
  endtask

  task automatic test_unmapped();
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic        err;
    int          waits;
    int          err_before;
    err_before = err_cnt;
    // One past the SRAM window, then one past the timer window
    bus_xfer(1'b0, 32'h0000_0400, WORD, '0, rdata, err, waits);
    check_value("mst_rsp_o.hresp", 32'(err), 32'd1);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits), 32'd1);
    bus_xfer(1'b1, 32'h0000_1010, WORD, 32'hDEAD_BEEF, rdata, err, waits);
    check_value("mst_rsp_o.hresp", 32'(err), 32'd1);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits), 32'd1);
    wdata = $random(seed);
    bus_write(sram_addr(8'h80), WORD, wdata);
    sram_model[8'h80] = wdata;
    sram_read(8'h80, rdata);
    check_value("mst_rsp_o.hrdata", rdata, sram_model[8'h80]);
    report_test("unmapped address", err_before);
  endtask

  task automatic test_pipelined();
    logic [31:0] cmp_val;
    logic [31:0] data_a;
    logic [31:0] data_b;
    int          waits_a;
    int          waits_b;
    int          err_before;
    err_before = err_cnt;
    cmp_val = $random(seed);
    bus_write(tmr_addr(TMR_CMP), WORD, cmp_val);
    // SRAM address phase sits in the timer wait state
    pipe_read2(tmr_addr(TMR_CMP), sram_addr(8'h40), data_a, data_b, waits_a, waits_b);
    check_value("mst_rsp_o.hrdata (timer)", data_a, cmp_val);
    check_value("mst_rsp_o.hrdata (SRAM)", data_b, sram_model[8'h40]);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits_a), 32'd1);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits_b), 32'd0);
    // Timer address phase during the SRAM data phase
    pipe_read2(sram_addr(8'h80), tmr_addr(TMR_CTRL), data_a, data_b, waits_a, waits_b);
    check_value("mst_rsp_o.hrdata (SRAM)", data_a, sram_model[8'h80]);
    check_value("mst_rsp_o.hrdata (timer)", data_b, 32'd0);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits_a), 32'd0);
    check_value("mst_rsp_o.hreadyout low cycles", 32'(waits_b), 32'd1);
    report_test("pipelined routing", err_before);
  endtask

  initial begin
    hreset_n   = 1'b0;
    mst_req    = idle_req();
    mst_hwdata = '0;
    repeat (RESET_CYCLES) @(posedge hclk);
    hreset_n <= 1'b1;
    @(posedge hclk);
    test_sram_words();
    test_sram_merge();
    test_timer_count();
    test_timer_irq();
    test_unmapped();
    test_pipelined();
    repeat (2) @(posedge hclk);
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             test_cnt, pass_cnt, test_cnt - pass_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the transfer budget
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: no result after %0d ns, the bus appears stuck", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/ahb_pkg.sv
rtl/ahb_node.sv
rtl/ahb_sram_slave.sv
rtl/ahb_timer_slave.sv
rtl/ahb_error_slave.sv
rtl/ahb_subsystem_top.sv
verification/tb_ahb_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the AHB-Lite subsystem testbench with Verilator and runs it.
# Exits non-zero unless the simulation output reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module tb_ahb_subsystem \
  -f verilog.f \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_ahb_subsystem)"
echo "$sim_out"

echo "$sim_out" | grep -qx "RESULT: PASS" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
